//--- common/cpu_pkg.sv
// ************************************************************************
// Shared definitions for the multi-cycle core: opcode and sub-opcode
// encodings, controller state codes, ALU and immediate select codes, and
// the packed instruction word with its decode views.
// Import it inside a module body; use scoped names in port headers.
// ************************************************************************
`default_nettype none

package cpu_pkg;

  localparam int INSTR_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // major opcodes, bits 30:25
  localparam logic [5:0] OP_BASIC = 6'b100000;
  localparam logic [5:0] OP_LS = 6'b011100;
  localparam logic [5:0] OP_ADDI = 6'b101000;
  localparam logic [5:0] OP_ORI = 6'b101100;
  localparam logic [5:0] OP_XORI = 6'b101011;
  localparam logic [5:0] OP_MOVI = 6'b100010;
  localparam logic [5:0] OP_LWI = 6'b000010;
  localparam logic [5:0] OP_SWI = 6'b001010;

  // OP_BASIC sub-opcodes, bits 4:0
  localparam logic [4:0] SUB_ADD = 5'b00000;
  localparam logic [4:0] SUB_SUB = 5'b00001;
  localparam logic [4:0] SUB_AND = 5'b00010;
  localparam logic [4:0] SUB_OR = 5'b00100;
  localparam logic [4:0] SUB_XOR = 5'b00011;
  localparam logic [4:0] SUB_SRLI = 5'b01001;
  localparam logic [4:0] SUB_SLLI = 5'b01000;
  localparam logic [4:0] SUB_ROTRI = 5'b01011;

  // OP_LS sub-opcodes, bits 7:0
  localparam logic [7:0] SUB8_LW = 8'b00000010;
  localparam logic [7:0] SUB8_SW = 8'b00001010;

  // listed in sequence order
  typedef enum logic [2:0] {
    ST_STOP = 3'd0,
    ST_FETCH = 3'd1,
    ST_EXE = 3'd2,
    ST_LW_FETCH = 3'd4,
    ST_LW_WRITE = 3'd5,
    ST_WRITE = 3'd3,
    ST_SW_FETCH = 3'd6,
    ST_SW_WRITE = 3'd7
  } ctrl_state_t;

  typedef enum logic [1:0] {
    SEL_IMM5_ZE = 2'b00,
    SEL_IMM15_SE = 2'b01,
    SEL_IMM15_ZE = 2'b10,
    SEL_IMM20_SE = 2'b11
  } imm_sel_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SRL = 3'd5,
    ALU_SLL = 3'd6,
    ALU_ROTR = 3'd7
  } alu_op_t;

  // rb slot doubles as imm5 for the shift-by-immediate ops
  typedef struct packed {
    logic rsvd;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [1:0] sv;
    logic [2:0] ext;
    logic [4:0] sub5;
  } basic_fmt_t;

  typedef struct packed {
    logic rsvd;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [1:0] sv;
    logic [7:0] sub8;
  } ls_fmt_t;

  typedef struct packed {
    logic rsvd;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [14:0] imm15;
  } imm_fmt_t;

  typedef struct packed {
    logic rsvd;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [19:0] imm20;
  } movi_fmt_t;

  typedef union packed {
    basic_fmt_t basic_f;
    ls_fmt_t ls_f;
    imm_fmt_t imm_f;
    movi_fmt_t movi_f;
  } instr_t;

endpackage

`default_nettype wire

//--- controller/ir_controller.sv
// ************************************************************************
// Instruction-register controller. Steps a fixed eight-state sequence per
// instruction, holds pc and the instruction word, decodes the fields and
// issues the registered enable strobes to memories, register file and ALU.
// The first ST_STOP after reset lasts two cycles while im_enable rises.
// ************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ir_controller #(
  parameter int IM_ADDR_WIDTH = 10
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic [cpu_pkg::INSTR_WIDTH-1:0] ir,
  output logic im_enable,
  output logic [IM_ADDR_WIDTH-1:0] im_address,
  output logic dm_enable,
  output logic dm_write,
  output logic reg_read,
  output logic reg_write,
  output logic alu_execute,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] read_address1,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] read_address2,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] write_address,
  output cpu_pkg::alu_op_t alu_op,
  output cpu_pkg::imm_sel_t imm_sel,
  output logic use_imm,
  output logic shift_by_sv,
  output logic [1:0] sv,
  output logic [19:0] imm20,
  output logic writeback_select,
  output logic [31:0] ins_cnt
);

  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  instr_t ir_q;
  instr_t cur;
  logic [IM_ADDR_WIDTH-1:0] pc;
  logic [5:0] opcode;
  logic [4:0] sub5;
  logic is_basic;
  logic is_load;
  logic is_store;
  logic is_nop;

  // during ST_FETCH the incoming word is decoded directly so the register
  // read can happen on the same edge that loads ir_q
  assign cur = (state == ST_FETCH) ? instr_t'(ir) : ir_q;

  assign opcode = cur.basic_f.opcode;
  assign sub5 = cur.basic_f.sub5;
  assign is_basic = (opcode == OP_BASIC);
  assign is_load = (opcode == OP_LWI) || (opcode == OP_LS && cur.ls_f.sub8 == SUB8_LW);
  assign is_store = (opcode == OP_SWI) || (opcode == OP_LS && cur.ls_f.sub8 == SUB8_SW);
  assign is_nop = is_basic && sub5 == SUB_SRLI && cur.basic_f.rt == '0 &&
                  cur.basic_f.ra == '0 && cur.basic_f.rb == '0;

  always_comb begin
    case (state)
      ST_STOP: next_state = im_enable ? ST_FETCH : ST_STOP;
      ST_FETCH: next_state = ST_EXE;
      ST_EXE: next_state = ST_LW_FETCH;
      ST_LW_FETCH: next_state = ST_LW_WRITE;
      ST_LW_WRITE: next_state = ST_WRITE;
      ST_WRITE: next_state = ST_SW_FETCH;
      ST_SW_FETCH: next_state = ST_SW_WRITE;
      default: next_state = ST_STOP;
    endcase
  end

  // strobes registered from the state about to be entered
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_STOP;
      im_enable <= 1'b0;
      reg_read <= 1'b0;
      alu_execute <= 1'b0;
      dm_enable <= 1'b0;
      dm_write <= 1'b0;
      reg_write <= 1'b0;
    end else begin
      state <= next_state;
      im_enable <= (next_state == ST_STOP);
      reg_read <= (next_state == ST_FETCH) || (next_state == ST_SW_FETCH && is_store);
      alu_execute <= (next_state == ST_EXE);
      dm_enable <= (next_state == ST_LW_FETCH && is_load) ||
                   (next_state == ST_SW_WRITE && is_store);
      dm_write <= (next_state == ST_SW_WRITE && is_store);
      reg_write <= (next_state == ST_WRITE) && !is_nop && !is_store;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ir_q <= '0;
      pc <= '0;
      ins_cnt <= '0;
    end else begin
      if (state == ST_FETCH) begin
        ir_q <= ir;
      end
      if (state == ST_SW_WRITE) begin
        pc <= pc + IM_ADDR_WIDTH'(4);
        if (ir_q != '0) begin
          ins_cnt <= ins_cnt + 32'd1;
        end
      end
    end
  end

  assign im_address = pc;

  // register addresses; movi has no ra so it reads r0
  assign read_address1 = (opcode == OP_MOVI) ? '0 : cur.basic_f.ra;
  assign read_address2 = (state == ST_SW_FETCH) ? cur.basic_f.rt : cur.basic_f.rb;
  assign write_address = cur.basic_f.rt;

  assign sv = cur.basic_f.sv;
  assign imm20 = cur.movi_f.imm20;
  assign shift_by_sv = (opcode == OP_LS);
  assign writeback_select = is_load;

  always_comb begin
    alu_op = ALU_ADD;
    imm_sel = SEL_IMM5_ZE;
    use_imm = 1'b1;
    case (opcode)
      OP_BASIC: begin
        use_imm = (sub5 == SUB_SRLI) || (sub5 == SUB_SLLI) || (sub5 == SUB_ROTRI);
        case (sub5)
          SUB_SUB: alu_op = ALU_SUB;
          SUB_AND: alu_op = ALU_AND;
          SUB_OR: alu_op = ALU_OR;
          SUB_XOR: alu_op = ALU_XOR;
          SUB_SRLI: alu_op = ALU_SRL;
          SUB_SLLI: alu_op = ALU_SLL;
          SUB_ROTRI: alu_op = ALU_ROTR;
          default: alu_op = ALU_ADD;
        endcase
      end
      OP_ADDI: imm_sel = SEL_IMM15_SE;
      OP_ORI: begin
        imm_sel = SEL_IMM15_ZE;
        alu_op = ALU_OR;
      end
      OP_XORI: begin
        imm_sel = SEL_IMM15_ZE;
        alu_op = ALU_XOR;
      end
      OP_LWI, OP_SWI: imm_sel = SEL_IMM15_ZE;
      OP_MOVI: imm_sel = SEL_IMM20_SE;
      // indexed address: ra + (rb << sv)
      OP_LS: use_imm = 1'b0;
      default: use_imm = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- datapath/alu.sv
// ************************************************************************
// ALU stage. Extends the immediate, selects the second operand, computes
// the result and registers it on alu_execute. The registered result is
// also the load/store byte address, and the write-back mux picks between
// it and the data-memory read word.
// ************************************************************************
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int DATA_WIDTH = 32,
  parameter int DM_ADDR_WIDTH = 10
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic alu_execute,
  input wire cpu_pkg::alu_op_t alu_op,
  input wire cpu_pkg::imm_sel_t imm_sel,
  input wire logic use_imm,
  input wire logic shift_by_sv,
  input wire logic [1:0] sv,
  input wire logic [19:0] imm20,
  input wire logic [DATA_WIDTH-1:0] rs1_data,
  input wire logic [DATA_WIDTH-1:0] rs2_data,
  input wire logic [DATA_WIDTH-1:0] dm_rdata,
  input wire logic writeback_select,
  output logic [DATA_WIDTH-1:0] alu_result,
  output logic [DM_ADDR_WIDTH-1:0] dm_address,
  output logic [DATA_WIDTH-1:0] write_data
);

  import cpu_pkg::*;

  localparam int SHIFT_WIDTH = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] imm_ext;
  logic [DATA_WIDTH-1:0] operand_pre;
  logic [DATA_WIDTH-1:0] operand_b;
  logic [DATA_WIDTH-1:0] result_n;
  logic [SHIFT_WIDTH-1:0] shamt;
  logic [2*DATA_WIDTH-1:0] rot_pair;

  // imm5 and imm15 both sit inside the low 20 bits of the word
  always_comb begin
    case (imm_sel)
      SEL_IMM5_ZE: imm_ext = {{(DATA_WIDTH-5){1'b0}}, imm20[14:10]};
      SEL_IMM15_SE: imm_ext = {{(DATA_WIDTH-15){imm20[14]}}, imm20[14:0]};
      SEL_IMM15_ZE: imm_ext = {{(DATA_WIDTH-15){1'b0}}, imm20[14:0]};
      default: imm_ext = {{(DATA_WIDTH-20){imm20[19]}}, imm20};
    endcase
  end

  assign operand_pre = use_imm ? imm_ext : rs2_data;
  // indexed load/store scales rb by 1, 2, 4 or 8
  assign operand_b = shift_by_sv ? (operand_pre << sv) : operand_pre;

  assign shamt = operand_b[SHIFT_WIDTH-1:0];
  assign rot_pair = {rs1_data, rs1_data} >> shamt;

  always_comb begin
    case (alu_op)
      ALU_ADD: result_n = rs1_data + operand_b;
      ALU_SUB: result_n = rs1_data - operand_b;
      ALU_AND: result_n = rs1_data & operand_b;
      ALU_OR: result_n = rs1_data | operand_b;
      ALU_XOR: result_n = rs1_data ^ operand_b;
      ALU_SRL: result_n = rs1_data >> shamt;
      ALU_SLL: result_n = rs1_data << shamt;
      default: result_n = rot_pair[DATA_WIDTH-1:0];
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (alu_execute) begin
      alu_result <= result_n;
    end
  end

  // word index into data memory
  assign dm_address = alu_result[DM_ADDR_WIDTH+1:2];
  assign write_data = writeback_select ? dm_rdata : alu_result;

endmodule

`default_nettype wire

//--- datapath/register_file.sv
// ************************************************************************
// General-purpose register file: 32 entries, two registered read ports
// loaded on reg_read and one write port on reg_write. Register 0 is never
// written and so always reads zero.
// ************************************************************************
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  parameter int DATA_WIDTH = 32
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic reg_read,
  input wire logic reg_write,
  input wire logic [cpu_pkg::REG_ADDR_WIDTH-1:0] read_address1,
  input wire logic [cpu_pkg::REG_ADDR_WIDTH-1:0] read_address2,
  input wire logic [cpu_pkg::REG_ADDR_WIDTH-1:0] write_address,
  input wire logic [DATA_WIDTH-1:0] write_data,
  output logic [DATA_WIDTH-1:0] rs1_data,
  output logic [DATA_WIDTH-1:0] rs2_data
);

  import cpu_pkg::*;

  localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      rs1_data <= '0;
      rs2_data <= '0;
    end else begin
      // r0 stays at its reset value
      if (reg_write && write_address != '0) begin
        regs[write_address] <= write_data;
      end
      if (reg_read) begin
        rs1_data <= regs[read_address1];
        rs2_data <= regs[read_address2];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
// ************************************************************************
// Core top level. Wires the controller, register file and ALU together
// and exposes the enable-style instruction and data memory ports.
// Memories sit outside and answer a strobe on the following clock.
// ************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int DATA_WIDTH = 32,
  parameter int IM_ADDR_WIDTH = 10,
  parameter int DM_ADDR_WIDTH = 10
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic [cpu_pkg::INSTR_WIDTH-1:0] ir,
  input wire logic [DATA_WIDTH-1:0] dm_rdata,
  output logic im_enable,
  output logic [IM_ADDR_WIDTH-1:0] im_address,
  output logic dm_enable,
  output logic dm_write,
  output logic [DM_ADDR_WIDTH-1:0] dm_address,
  output logic [DATA_WIDTH-1:0] dm_wdata,
  output logic [31:0] ins_cnt
);

  import cpu_pkg::*;

  logic reg_read;
  logic reg_write;
  logic alu_execute;
  logic [REG_ADDR_WIDTH-1:0] read_address1;
  logic [REG_ADDR_WIDTH-1:0] read_address2;
  logic [REG_ADDR_WIDTH-1:0] write_address;
  alu_op_t alu_op;
  imm_sel_t imm_sel;
  logic use_imm;
  logic shift_by_sv;
  logic [1:0] sv;
  logic [19:0] imm20;
  logic writeback_select;
  logic [DATA_WIDTH-1:0] rs1_data;
  logic [DATA_WIDTH-1:0] rs2_data;
  logic [DATA_WIDTH-1:0] alu_result;
  logic [DATA_WIDTH-1:0] write_data;

  ir_controller #(
    .IM_ADDR_WIDTH(IM_ADDR_WIDTH)
  ) u_controller (
    .clock(clock),
    .reset(reset),
    .ir(ir),
    .im_enable(im_enable),
    .im_address(im_address),
    .dm_enable(dm_enable),
    .dm_write(dm_write),
    .reg_read(reg_read),
    .reg_write(reg_write),
    .alu_execute(alu_execute),
    .read_address1(read_address1),
    .read_address2(read_address2),
    .write_address(write_address),
    .alu_op(alu_op),
    .imm_sel(imm_sel),
    .use_imm(use_imm),
    .shift_by_sv(shift_by_sv),
    .sv(sv),
    .imm20(imm20),
    .writeback_select(writeback_select),
    .ins_cnt(ins_cnt)
  );

  register_file #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_regs (
    .clock(clock),
    .reset(reset),
    .reg_read(reg_read),
    .reg_write(reg_write),
    .read_address1(read_address1),
    .read_address2(read_address2),
    .write_address(write_address),
    .write_data(write_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu #(
    .DATA_WIDTH(DATA_WIDTH),
    .DM_ADDR_WIDTH(DM_ADDR_WIDTH)
  ) u_alu (
    .clock(clock),
    .reset(reset),
    .alu_execute(alu_execute),
    .alu_op(alu_op),
    .imm_sel(imm_sel),
    .use_imm(use_imm),
    .shift_by_sv(shift_by_sv),
    .sv(sv),
    .imm20(imm20),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .dm_rdata(dm_rdata),
    .writeback_select(writeback_select),
    .alu_result(alu_result),
    .dm_address(dm_address),
    .write_data(write_data)
  );

  // store data is rt, read on port 2 during ST_SW_FETCH
  assign dm_wdata = rs2_data;

endmodule

`default_nettype wire

//--- project.f
+incdir+test
common/cpu_pkg.sv
controller/ir_controller.sv
datapath/register_file.sv
datapath/alu.sv
hdl/cpu_top.sv
test/cpu_properties.sv
test/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_sim || exit 1
output="$(./obj_dir/cpu_sim 2>&1)"
echo "$output"
grep -qx "TEST PASS" <<< "$output" && exit 0 || exit 1

//--- test/cpu_properties.sv
// ***************************************************************************
// Concurrent checks on the core's memory strobes, bound into the top level:
// instruction and data strobes never overlap, writes carry an enable,
// strobes are low out of reset, and fetches recur every 8 cycles.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
  input wire logic clock,
  input wire logic reset,
  input wire logic im_enable,
  input wire logic dm_enable,
  input wire logic dm_write
);

  logic [3:0] gap;
  logic seen;

  // cycles since the last fetch strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      gap <= 4'd0;
      seen <= 1'b0;
    end else if (im_enable) begin
      gap <= 4'd0;
      seen <= 1'b1;
    end else if (gap != 4'hf) begin
      gap <= gap + 4'd1;
    end
  end

  strobe_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(dm_enable && im_enable))
    else $error("data and instruction strobes overlap");

  write_has_enable: assert property (@(posedge clock) disable iff (reset)
    dm_write |-> dm_enable)
    else $error("dm_write without dm_enable");

  strobes_low_in_reset: assert property (@(posedge clock)
    reset |=> (!im_enable && !dm_enable && !dm_write))
    else $error("strobe active during reset");

  fetch_period: assert property (@(posedge clock) disable iff (reset)
    seen |-> (im_enable == (gap == 4'd7)))
    else $error("im_enable not on an 8-cycle period");

endmodule

bind cpu_top cpu_properties u_properties (
  .clock(clock),
  .reset(reset),
  .im_enable(im_enable),
  .dm_enable(dm_enable),
  .dm_write(dm_write)
);

`default_nettype wire

//--- test/tb_programs.svh
// ***************************************************************************
// Testbench helpers included into the core testbench module: encoders that
// assemble instruction words through the packed instruction union, and a
// software model that applies each instruction to mirror registers and a
// mirror data memory.
// ***************************************************************************
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] reg_op_word(input logic [4:0] sub5, input logic [4:0] rt,
                                            input logic [4:0] ra, input logic [4:0] rb);
  instr_t w;
  w = '0;
  w.basic_f.opcode = OP_BASIC;
  w.basic_f.rt = rt;
  w.basic_f.ra = ra;
  w.basic_f.rb = rb;
  w.basic_f.sub5 = sub5;
  return w;
endfunction

function automatic logic [31:0] imm_op_word(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] ra, input logic [14:0] imm15);
  instr_t w;
  w = '0;
  w.imm_f.opcode = op;
  w.imm_f.rt = rt;
  w.imm_f.ra = ra;
  w.imm_f.imm15 = imm15;
  return w;
endfunction

function automatic logic [31:0] movi_word(input logic [4:0] rt, input logic [19:0] imm20);
  instr_t w;
  w = '0;
  w.movi_f.opcode = OP_MOVI;
  w.movi_f.rt = rt;
  w.movi_f.imm20 = imm20;
  return w;
endfunction

function automatic logic [31:0] indexed_word(input logic [7:0] sub8, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [4:0] rb,
                                             input logic [1:0] sv);
  instr_t w;
  w = '0;
  w.ls_f.opcode = OP_LS;
  w.ls_f.rt = rt;
  w.ls_f.ra = ra;
  w.ls_f.rb = rb;
  w.ls_f.sv = sv;
  w.ls_f.sub8 = sub8;
  return w;
endfunction

// one instruction against the mirror state
function automatic void model_step(input logic [31:0] word);
  instr_t w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] addr;
  logic write_rt;
  w = word;
  a = model_regs[w.basic_f.ra];
  b = model_regs[w.basic_f.rb];
  res = '0;
  addr = '0;
  write_rt = 1'b1;
  case (w.basic_f.opcode)
    OP_BASIC: begin
      case (w.basic_f.sub5)
        SUB_ADD: res = a + b;
        SUB_SUB: res = a - b;
        SUB_AND: res = a & b;
        SUB_OR: res = a | b;
        SUB_XOR: res = a ^ b;
        SUB_SRLI: res = a >> w.basic_f.rb;
        SUB_SLLI: res = a << w.basic_f.rb;
        SUB_ROTRI: res = (a >> w.basic_f.rb) | (a << (6'd32 - {1'b0, w.basic_f.rb}));
        default: write_rt = 1'b0;
      endcase
    end
    OP_ADDI: res = a + {{17{w.imm_f.imm15[14]}}, w.imm_f.imm15};
    OP_ORI: res = a | {17'd0, w.imm_f.imm15};
    OP_XORI: res = a ^ {17'd0, w.imm_f.imm15};
    OP_MOVI: res = {{12{w.movi_f.imm20[19]}}, w.movi_f.imm20};
    OP_LWI: begin
      addr = a + {17'd0, w.imm_f.imm15};
      res = model_dmem[addr[11:2]];
    end
    OP_SWI: begin
      addr = a + {17'd0, w.imm_f.imm15};
      model_dmem[addr[11:2]] = model_regs[w.imm_f.rt];
      model_store_count++;
      write_rt = 1'b0;
    end
    OP_LS: begin
      addr = a + (b << w.ls_f.sv);
      write_rt = 1'b0;
      if (w.ls_f.sub8 == SUB8_LW) begin
        res = model_dmem[addr[11:2]];
        write_rt = 1'b1;
      end else if (w.ls_f.sub8 == SUB8_SW) begin
        model_dmem[addr[11:2]] = model_regs[w.ls_f.rt];
        model_store_count++;
      end
    end
    default: write_rt = 1'b0;
  endcase
  if (write_rt && w.basic_f.rt != 5'd0) begin
    model_regs[w.basic_f.rt] = res;
  end
endfunction

`endif

//--- test/cpu_tb.sv
// ***************************************************************************
// Directed testbench for the multi-cycle core. Models both memories with a
// one-cycle read latency, runs short programs, and compares data memory,
// store count and ins_cnt against a software model of the instructions.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  import cpu_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_PROG_LEN = 64;
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * ((MAX_PROG_LEN + 2) * 8 + RESET_CYCLES + 4) + 200;

  logic clock;
  logic reset;
  logic [31:0] ir = '0;
  logic [31:0] dm_rdata = '0;
  wire logic im_enable;
  wire logic [9:0] im_address;
  wire logic dm_enable;
  wire logic dm_write;
  wire logic [9:0] dm_address;
  wire logic [31:0] dm_wdata;
  wire logic [31:0] ins_cnt;

  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] imem_image [1024];
  logic [31:0] dmem_image [1024];
  logic [31:0] model_regs [32];
  logic [31:0] model_dmem [1024];
  logic [31:0] prog [$];
  logic [31:0] rng_state = 32'hb03b;
  logic fetch_due;
  logic read_due;
  logic [31:0] fetch_word;
  logic [31:0] read_word;
  int model_store_count;
  int store_count;
  int errors;
  int test_errors;
  int tests_run;

  cpu_top #(
    .DATA_WIDTH(32),
    .IM_ADDR_WIDTH(10),
    .DM_ADDR_WIDTH(10)
  ) UUT (
    .clock(clock),
    .reset(reset),
    .ir(ir),
    .dm_rdata(dm_rdata),
    .im_enable(im_enable),
    .im_address(im_address),
    .dm_enable(dm_enable),
    .dm_write(dm_write),
    .dm_address(dm_address),
    .dm_wdata(dm_wdata),
    .ins_cnt(ins_cnt)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // memories reload their images while reset is held
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        imem[i] = imem_image[i];
        dmem[i] = dmem_image[i];
      end
      store_count = 0;
    end else begin
      fetch_due = im_enable;
      read_due = dm_enable && !dm_write;
      fetch_word = imem[{2'b00, im_address[9:2]}];
      read_word = dmem[dm_address];
      if (dm_enable && dm_write) begin
        dmem[dm_address] = dm_wdata;
        store_count++;
      end
      // read data appears just after the edge that sampled the strobe
      if (fetch_due || read_due) begin
        #1;
        if (fetch_due) begin
          ir = fetch_word;
        end
        if (read_due) begin
          dm_rdata = read_word;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] dm_fill(input int a);
    logic [31:0] ua;
    ua = a;
    return (ua + 32'd1) * 32'h9e3779b9;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // full 32-bit constant via movi, slli and ori
  task automatic load_const(input logic [4:0] rt, input logic [31:0] value);
    emit(movi_word(rt, value[31:12]));
    emit(reg_op_word(SUB_SLLI, rt, rt, 5'd12));
    emit(imm_op_word(OP_ORI, rt, rt, {3'b000, value[11:0]}));
  endtask

  task automatic load_and_reset();
    @(posedge clock);
    #1 reset = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      imem_image[i] = (i < prog.size()) ? prog[i] : 32'd0;
      dmem_image[i] = dm_fill(i);
      model_dmem[i] = dm_fill(i);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_store_count = 0;
    foreach (prog[i]) begin
      model_step(prog[i]);
    end
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
  endtask

  task automatic run_and_check(input string name);
    int pulses;
    int nonzero;
    test_errors = 0;
    nonzero = 0;
    assert (prog.size() <= MAX_PROG_LEN)
    else begin
      $display("Program for %s is longer than %0d words", name, MAX_PROG_LEN);
      test_errors++;
    end
    foreach (prog[i]) begin
      if (prog[i] != 32'd0) nonzero++;
    end
    load_and_reset();
    // fetch of the word after the last one marks the program done
    pulses = 0;
    while (pulses < prog.size() + 1) begin
      @(negedge clock);
      if (im_enable) pulses++;
    end
    for (int i = 0; i < 1024; i++) begin
      check_word($sformatf("dmem[%0d]", i), dmem[i], model_dmem[i]);
    end
    check_word("store_count", store_count, model_store_count);
    check_word("ins_cnt", ins_cnt, nonzero);
    $display("[done] %s errors=%0d", name, test_errors);
    errors += test_errors;
    tests_run++;
  endtask

  task automatic register_ops_test();
    logic [4:0] base;
    prog.delete();
    for (int k = 0; k < 2; k++) begin
      base = 5'(k * 8);
      load_const(5'd1, next_random());
      load_const(5'd2, next_random());
      emit(reg_op_word(SUB_ADD, 5'd3, 5'd1, 5'd2));
      emit(reg_op_word(SUB_SUB, 5'd4, 5'd1, 5'd2));
      emit(reg_op_word(SUB_AND, 5'd5, 5'd1, 5'd2));
      emit(reg_op_word(SUB_OR, 5'd6, 5'd1, 5'd2));
      emit(reg_op_word(SUB_XOR, 5'd7, 5'd1, 5'd2));
      for (int r = 3; r < 8; r++) begin
        emit(imm_op_word(OP_SWI, 5'(r), 5'd0, 15'h0040 + 15'({base, 2'b00}) + 15'(r * 4)));
      end
    end
    run_and_check("register_ops");
  endtask

  task automatic immediate_ops_test();
    logic [31:0] r;
    prog.delete();
    load_const(5'd1, next_random());
    r = next_random();
    emit(imm_op_word(OP_ADDI, 5'd2, 5'd1, 15'h7ff0));
    emit(imm_op_word(OP_ADDI, 5'd3, 5'd1, {1'b1, r[13:0]}));
    emit(imm_op_word(OP_ORI, 5'd4, 5'd1, {1'b1, r[27:14]}));
    emit(imm_op_word(OP_XORI, 5'd5, 5'd1, r[31:17]));
    emit(movi_word(5'd6, {1'b1, r[18:0]}));
    for (int k = 2; k < 7; k++) begin
      emit(imm_op_word(OP_SWI, 5'(k), 5'd0, 15'h0100 + 15'(k * 4)));
    end
    run_and_check("immediate_ops");
  endtask

  task automatic shifts_test();
    logic [4:0] amt;
    prog.delete();
    load_const(5'd1, next_random());
    for (int k = 0; k < 3; k++) begin
      amt = 5'(next_random());
      emit(reg_op_word(SUB_SRLI, 5'd2, 5'd1, amt));
      emit(reg_op_word(SUB_SLLI, 5'd3, 5'd1, amt));
      emit(reg_op_word(SUB_ROTRI, 5'd4, 5'd1, amt));
      emit(imm_op_word(OP_SWI, 5'd2, 5'd0, 15'h0200 + 15'(k * 12)));
      emit(imm_op_word(OP_SWI, 5'd3, 5'd0, 15'h0204 + 15'(k * 12)));
      emit(imm_op_word(OP_SWI, 5'd4, 5'd0, 15'h0208 + 15'(k * 12)));
    end
    run_and_check("shifts");
  endtask

  task automatic loads_stores_test();
    prog.delete();
    emit(imm_op_word(OP_LWI, 5'd1, 5'd0, 15'h0010));
    emit(imm_op_word(OP_SWI, 5'd1, 5'd0, 15'h0800));
    emit(movi_word(5'd2, 20'h00200));
    emit(movi_word(5'd3, 20'h00004));
    emit(movi_word(5'd5, 20'h00600));
    for (int s = 0; s < 4; s++) begin
      emit(indexed_word(SUB8_LW, 5'd4, 5'd2, 5'd3, 2'(s)));
      emit(indexed_word(SUB8_SW, 5'd4, 5'd5, 5'd3, 2'(s)));
    end
    emit(imm_op_word(OP_LWI, 5'd6, 5'd2, 15'h0024));
    emit(imm_op_word(OP_SWI, 5'd6, 5'd5, 15'h0040));
    run_and_check("loads_stores");
  endtask

  task automatic nop_and_r0_test();
    prog.delete();
    load_const(5'd1, next_random());
    emit(reg_op_word(SUB_SRLI, 5'd0, 5'd0, 5'd0));
    emit(reg_op_word(SUB_SRLI, 5'd0, 5'd0, 5'd0));
    emit(imm_op_word(OP_SWI, 5'd1, 5'd0, 15'h0300));
    emit(movi_word(5'd0, 20'h12345));
    emit(imm_op_word(OP_ADDI, 5'd0, 5'd1, 15'h0001));
    emit(imm_op_word(OP_SWI, 5'd0, 5'd0, 15'h0304));
    emit(32'd0);
    emit(reg_op_word(SUB_SRLI, 5'd0, 5'd0, 5'd0));
    emit(imm_op_word(OP_SWI, 5'd1, 5'd0, 15'h0308));
    run_and_check("nop_and_r0");
  endtask

  task automatic fetch_timing_test();
    int pulses;
    int cycle;
    int last_cycle;
    logic [9:0] last_addr;
    test_errors = 0;
    prog.delete();
    repeat (8) emit(reg_op_word(SUB_SRLI, 5'd0, 5'd0, 5'd0));
    load_and_reset();
    pulses = 0;
    cycle = 0;
    last_cycle = 0;
    last_addr = '0;
    while (pulses < 5) begin
      @(negedge clock);
      cycle++;
      if (im_enable) begin
        if (pulses == 0) begin
          check_word("im_address", {22'd0, im_address}, 32'd0);
        end else begin
          check_word("fetch_gap", cycle - last_cycle, 32'd8);
          check_word("im_address", {22'd0, im_address}, {22'd0, last_addr + 10'd4});
        end
        last_cycle = cycle;
        last_addr = im_address;
        pulses++;
      end
    end
    $display("[done] fetch_timing errors=%0d", test_errors);
    errors += test_errors;
    tests_run++;
  endtask

  initial begin
    reset = 1'b1;
    errors = 0;
    tests_run = 0;
    register_ops_test();
    immediate_ops_test();
    shifts_test();
    loads_stores_test();
    nop_and_r0_test();
    fetch_timing_test();
    $display("tests=%0d errors=%0d", tests_run, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  `include "tb_programs.svh"

endmodule

`default_nettype wire
